//--- fault_capture.sv
/*
 * Fault capture for one source.
 * Latches the first occurrence of each fault kind and queues
 * one log request per new kind, lowest kind first.
 */
`timescale 1ns/1ns

module fault_capture #(
  parameter bit SrcId = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [fault_pkg::FaultW-1:0] fault_i,
  input  logic                         clear_i,
  output logic [fault_pkg::FaultW-1:0] seen_o,
  log_if.producer                      log_o
);
  import fault_pkg::*;

  logic [FaultW-1:0] seen_q;
  logic [FaultW-1:0] pend_q;
  logic [FaultW-1:0] pend_d;
  logic [FaultW-1:0] new_hits;
  logic [FaultW-1:0] done_mask;
  logic              req_q;
  logic              xfer;
  fault_kind_e       kind_q;
  fault_kind_e       next_kind;

  // Lines are modulated, only a clear seen bit counts.
  assign new_hits = fault_i & ~seen_q;
  // Request handed over at this edge.
  assign xfer = req_q & log_o.gnt;

  // Granted kind leaves the pending set.
  always_comb begin
    done_mask = '0;
    if (xfer) begin
      done_mask[kind_q] = 1'b1;
    end
  end

  assign pend_d = (pend_q & ~done_mask) | new_hits;

  // Lowest pending kind goes next.
  always_comb begin
    next_kind = bounds;
    for (int i = FaultW - 1; i >= 0; i--) begin
      if (pend_d[i]) begin
        next_kind = fault_kind_e'(4'(i));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
      pend_q <= '0;
      req_q  <= 1'b0;
    end else if (clear_i) begin
      seen_q <= '0;
      pend_q <= '0;
      req_q  <= 1'b0;
    end else begin
      seen_q <= seen_q | fault_i;
      pend_q <= pend_d;
      // New request only once the open one is gone.
      if (!req_q || xfer) begin
        req_q <= |pend_d;
      end
    end
  end

  // Kind follows the pending set while no request is held.
  always_ff @(posedge clk_i) begin
    if (!req_q || xfer) begin
      kind_q <= next_kind;
    end
  end

  assign seen_o    = seen_q;
  assign log_o.req  = req_q;
  assign log_o.src  = SrcId;
  assign log_o.kind = kind_q;

  // Payload holds until the arbiter takes it.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    log_o.req && !log_o.gnt && !clear_i |=> $stable(log_o.kind));

  // An open request always names a pending kind.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    log_o.req |-> pend_q[log_o.kind]);

endmodule

//--- fault_pkg.sv
/*
 * Shared definitions for the capability-fault log.
 * Fault kinds, log sizes and the layout of one log record.
 */

package fault_pkg;

  // Fault lines per source, one per fault kind.
  localparam int unsigned FaultW = 9;
  // Fault sources sharing the log.
  localparam int unsigned NumSrc = 2;

  // Log storage geometry.
  localparam int unsigned LogDepth  = 16;
  localparam int unsigned LogAddrW  = 4;
  // One bit wider than the address so a full log is countable.
  localparam int unsigned LogCountW = 5;

  // Free-running cycle stamp, wraps after 2048 cycles.
  localparam int unsigned StampW = 11;

  // Fault kinds in fault line index order.
  typedef enum logic [3:0] {
    bounds               = 4'd0,
    tag                  = 4'd1,
    seal                 = 4'd2,
    perm_exec            = 4'd3,
    perm_load            = 4'd4,
    perm_store           = 4'd5,
    perm_store_cap       = 4'd6,
    perm_store_local_cap = 4'd7,
    acc_sys_regs         = 4'd8
  } fault_kind_e;

  // One log entry, 16 bits.
  typedef struct packed {
    logic [$clog2(NumSrc)-1:0] src;
    fault_kind_e               kind;
    logic [StampW-1:0]         stamp;
  } log_rec_t;

endpackage

//--- fault_report_top.sv
/*
 * Capability-fault report top level.
 * Two capture blocks share one fault log through an arbiter.
 */
`timescale 1ns/1ns

module fault_report_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [fault_pkg::FaultW-1:0]            fault0_i,
  input  logic [fault_pkg::FaultW-1:0]            fault1_i,
  input  logic                                    clear_i,
  input  logic [fault_pkg::LogAddrW-1:0]          rd_addr_i,
  output logic [$bits(fault_pkg::log_rec_t)-1:0]  rd_data_o,
  output logic [fault_pkg::LogCountW-1:0]         log_count_o,
  output logic [fault_pkg::FaultW-1:0]            seen0_o,
  output logic [fault_pkg::FaultW-1:0]            seen1_o
);
  import fault_pkg::*;

  // Request buses, one per source.
  log_if log0 ();
  log_if log1 ();

  // Log write port.
  logic                wr_en;
  logic [LogAddrW-1:0] wr_addr;
  log_rec_t            wr_data;

  fault_capture #(
    .SrcId (1'b0)
  ) u_capture0 (
    .clk_i,
    .rst_ni,
    .fault_i (fault0_i),
    .clear_i,
    .seen_o  (seen0_o),
    .log_o   (log0)
  );

  fault_capture #(
    .SrcId (1'b1)
  ) u_capture1 (
    .clk_i,
    .rst_ni,
    .fault_i (fault1_i),
    .clear_i,
    .seen_o  (seen1_o),
    .log_o   (log1)
  );

  log_arbiter u_arbiter (
    .clk_i,
    .rst_ni,
    .clear_i,
    .req0        (log0),
    .req1        (log1),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .log_count_o (log_count_o)
  );

  // Host reads the log directly.
  log_ram u_log_ram (
    .clk_i,
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

//--- log_arbiter.sv
/*
 * Round-robin arbiter for the shared fault log.
 * Stamps each granted request with the cycle count and writes it
 * at the next free log slot, holding grants while the log is full.
 */
`timescale 1ns/1ns

module log_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  log_if.consumer                         req0,
  log_if.consumer                         req1,
  output logic                            wr_en_o,
  output logic [fault_pkg::LogAddrW-1:0]  wr_addr_o,
  output fault_pkg::log_rec_t             wr_data_o,
  output logic [fault_pkg::LogCountW-1:0] log_count_o
);
  import fault_pkg::*;

  logic                 last_q;
  logic [StampW-1:0]    stamp_q;
  logic [LogCountW-1:0] count_q;
  logic                 full;
  logic                 gnt0;
  logic                 gnt1;

  // Log holds LogDepth records.
  assign full = (count_q == LogCountW'(LogDepth));

  // Grant selection.
  always_comb begin
    gnt0 = 1'b0;
    gnt1 = 1'b0;
    if (!full && !clear_i) begin
      if (req0.req && req1.req) begin
        // Contention goes to the source not granted last.
        gnt0 = last_q;
        gnt1 = ~last_q;
      end else begin
        gnt0 = req0.req;
        gnt1 = req1.req;
      end
    end
  end

  assign req0.gnt = gnt0;
  assign req1.gnt = gnt1;

  // Record from the granted source.
  always_comb begin
    wr_data_o.stamp = stamp_q;
    if (gnt1) begin
      wr_data_o.src  = req1.src;
      wr_data_o.kind = req1.kind;
    end else begin
      wr_data_o.src  = req0.src;
      wr_data_o.kind = req0.kind;
    end
  end

  // One write per cycle, at the current count.
  assign wr_en_o   = gnt0 | gnt1;
  assign wr_addr_o = count_q[LogAddrW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Source 0 wins the first contention.
      last_q  <= 1'b1;
      stamp_q <= '0;
      count_q <= '0;
    end else begin
      // Stamp runs on through clears and wraps.
      stamp_q <= stamp_q + 1'b1;
      if (wr_en_o) begin
        last_q <= gnt1;
      end
      if (clear_i) begin
        count_q <= '0;
      end else if (wr_en_o) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign log_count_o = count_q;

  // Only one source written per cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(gnt0 && gnt1));

  // Count stays within the log.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= LogCountW'(LogDepth));

  // Grant only goes to an open request.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req0.gnt -> req0.req) && (req1.gnt -> req1.req));

endmodule

//--- log_if.sv
/*
 * Log write-request bus from a capture block to the arbiter.
 * Request payload holds steady until a clock edge with grant high.
 */
`timescale 1ns/1ns

interface log_if;
  import fault_pkg::*;

  // Request open, level only.
  logic                      req;
  // Source number of the requester.
  logic [$clog2(NumSrc)-1:0] src;
  // Fault kind to log.
  fault_kind_e               kind;
  // Grant, combinational in the arbiter.
  logic                      gnt;

  // Capture side.
  modport producer (
    output req, src, kind,
    input  gnt
  );

  // Arbiter side.
  modport consumer (
    input  req, src, kind,
    output gnt
  );

endinterface

//--- log_ram.sv
/*
 * Fault log storage.
 * One synchronous write port and one registered read port.
 */
`timescale 1ns/1ns

module log_ram (
  input  logic                           clk_i,
  input  logic                           wr_en_i,
  input  logic [fault_pkg::LogAddrW-1:0] wr_addr_i,
  input  fault_pkg::log_rec_t            wr_data_i,
  input  logic [fault_pkg::LogAddrW-1:0] rd_addr_i,
  output fault_pkg::log_rec_t            rd_data_o
);
  import fault_pkg::*;

  log_rec_t mem_q [LogDepth];
  log_rec_t rd_data_q;

  // Write at the grant edge.
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read data one cycle after the address.
  always_ff @(posedge clk_i) begin
    rd_data_q <= mem_q[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fault report testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_fault_report \
  -o sim_fault_report

./obj_dir/sim_fault_report > sim.log 2>&1 || true
cat sim.log

# The log decides the outcome.
if grep -qx "Regression passed" sim.log; then
  echo "Simulation status: PASS"
  exit 0
else
  echo "Simulation status: FAIL"
  exit 1
fi

//--- tb_fault_report.sv
/*
 * Testbench for the capability-fault report top level.
 * Table-driven modulated fault stimulus, checked against a queue model of the log.
 */
`timescale 1ns/1ns

module tb_fault_report;
  import fault_pkg::*;

  logic                 clk_i;
  logic                 rst_ni;
  logic [FaultW-1:0]    fault0_i;
  logic [FaultW-1:0]    fault1_i;
  logic                 clear_i;
  logic [LogAddrW-1:0]  rd_addr_i;
  logic [15:0]          rd_data_o;
  logic [LogCountW-1:0] log_count_o;
  logic [FaultW-1:0]    seen0_o;
  logic [FaultW-1:0]    seen1_o;

  // One stimulus row.
  typedef struct {
    logic [FaultW-1:0]    pat0;
    logic [FaultW-1:0]    pat1;
    int unsigned          reps;
    bit                   clr;
    logic [FaultW-1:0]    exp_seen0;
    logic [FaultW-1:0]    exp_seen1;
    logic [LogCountW-1:0] exp_count;
  } row_t;

  row_t              rows[$];
  // Reference model, kinds per source in logging order.
  logic [3:0]        model_q0[$];
  logic [3:0]        model_q1[$];
  logic [FaultW-1:0] model_seen0;
  logic [FaultW-1:0] model_seen1;
  int                errors;
  int                checks;

  fault_report_top dut_i (
    .clk_i,
    .rst_ni,
    .fault0_i,
    .fault1_i,
    .clear_i,
    .rd_addr_i,
    .rd_data_o,
    .log_count_o,
    .seen0_o,
    .seen1_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic add_row(input logic [FaultW-1:0] p0, input logic [FaultW-1:0] p1,
                         input int unsigned n, input bit clr, input logic [FaultW-1:0] s0,
                         input logic [FaultW-1:0] s1, input logic [LogCountW-1:0] cnt);
    row_t r;
    r.pat0      = p0;
    r.pat1      = p1;
    r.reps      = n;
    r.clr       = clr;
    r.exp_seen0 = s0;
    r.exp_seen1 = s1;
    r.exp_count = cnt;
    rows.push_back(r);
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("** Error: %s got %h, expected %h", name, got, exp);
    end
  endtask

  // First occurrences of a row, lowest kind first per source.
  task automatic update_model(input row_t r);
    if (r.clr) begin
      model_q0.delete();
      model_q1.delete();
      model_seen0 = '0;
      model_seen1 = '0;
    end
    for (int k = 0; k < FaultW; k++) begin
      if (r.pat0[k] && !model_seen0[k]) model_q0.push_back(4'(k));
      if (r.pat1[k] && !model_seen1[k]) model_q1.push_back(4'(k));
    end
    model_seen0 = model_seen0 | r.pat0;
    model_seen1 = model_seen1 | r.pat1;
  endtask

  // Each source must show a prefix of its model queue.
  // One write per cycle, so stamps rise strictly until the wrap.
  task automatic read_log(input int n);
    log_rec_t          rec;
    int                n0;
    int                n1;
    logic [3:0]        exp_kind;
    logic [StampW-1:0] prev;
    n0   = 0;
    n1   = 0;
    prev = '0;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      rd_addr_i = LogAddrW'(i);
      @(negedge clk_i);
      rec = log_rec_t'(rd_data_o);
      if (rec.src == 1'b0) begin
        exp_kind = (n0 < model_q0.size()) ? model_q0[n0] : 4'hf;
        n0++;
      end else begin
        exp_kind = (n1 < model_q1.size()) ? model_q1[n1] : 4'hf;
        n1++;
      end
      checks++;
      assert (rec.kind == exp_kind) else begin
        errors++;
        $display("** Error: rd_data_o kind at addr %h (src %h) got %h, expected %h",
                 i, rec.src, rec.kind, exp_kind);
      end
      if (i > 0) begin
        checks++;
        assert (rec.stamp > prev) else begin
          errors++;
          $display("** Error: rd_data_o stamp at addr %h got %h, not above previous %h",
                   i, rec.stamp, prev);
        end
      end
      prev = rec.stamp;
    end
  endtask

  task automatic run_row(input row_t r);
    int unsigned phase;
    int          cycles;
    int          total;
    phase = $urandom() & 1;
    if (r.clr) begin
      @(negedge clk_i);
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
    end
    // Modulated lines, on every other cycle.
    for (int unsigned c = 0; c < r.reps; c++) begin
      @(negedge clk_i);
      fault0_i = (((c + phase) % 2) == 0) ? r.pat0 : '0;
      fault1_i = (((c + phase) % 2) == 0) ? r.pat1 : '0;
    end
    @(negedge clk_i);
    fault0_i = '0;
    fault1_i = '0;
    update_model(r);
    total = model_q0.size() + model_q1.size();
    if (total > LogDepth) total = LogDepth;
    assert (total == int'(r.exp_count)) else begin
      errors++;
      $display("Stimulus table count %0d disagrees with the reference model %0d",
               r.exp_count, total);
    end
    cycles = 0;
    while (log_count_o != r.exp_count && cycles < 200) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= 200) begin
      errors++;
      $display("Timeout while waiting for the log count to settle");
    end
    check_val("log_count_o", 16'(log_count_o), 16'(r.exp_count));
    check_val("seen0_o", 16'(seen0_o), 16'(r.exp_seen0));
    check_val("seen1_o", 16'(seen1_o), 16'(r.exp_seen1));
    read_log(int'(r.exp_count));
    // No late writes after the readback.
    check_val("log_count_o", 16'(log_count_o), 16'(r.exp_count));
  endtask

  initial begin
    void'($urandom(93));
    errors      = 0;
    checks      = 0;
    model_seen0 = '0;
    model_seen1 = '0;
    rst_ni      = 1'b0;
    fault0_i    = '0;
    fault1_i    = '0;
    clear_i     = 1'b0;
    rd_addr_i   = '0;
    // Reset state, single kind, repeat, burst, both sources, overflow, clear.
    add_row(9'h000, 9'h000, 1,  1'b0, 9'h000, 9'h000, 5'd0);
    add_row(9'h004, 9'h000, 8,  1'b0, 9'h004, 9'h000, 5'd1);
    add_row(9'h004, 9'h000, 6,  1'b0, 9'h004, 9'h000, 5'd1);
    add_row(9'h0a2, 9'h000, 6,  1'b0, 9'h0a6, 9'h000, 5'd4);
    add_row(9'h009, 9'h111, 10, 1'b0, 9'h0af, 9'h111, 5'd9);
    add_row(9'h1ff, 9'h1ff, 10, 1'b0, 9'h1ff, 9'h1ff, 5'd16);
    add_row(9'h000, 9'h000, 2,  1'b1, 9'h000, 9'h000, 5'd0);
    add_row(9'h004, 9'h000, 6,  1'b0, 9'h004, 9'h000, 5'd1);
    add_row(9'h004, 9'h100, 6,  1'b0, 9'h004, 9'h100, 5'd2);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
fault_pkg.sv
log_if.sv
fault_capture.sv
log_arbiter.sv
log_ram.sv
fault_report_top.sv
tb_fault_report.sv
